// File: include/wb_consts.svh
// ------------------------------------------------------------
// bus and memory sizes for the wishbone memory link
// include this wherever a width or the memory depth is needed
// ------------------------------------------------------------
`ifndef WB_CONSTS_SVH
`define WB_CONSTS_SVH

// byte address and data widths
`define WB_ADDR_W 32
`define WB_DATA_W 32

// one select bit per byte lane
`define WB_SEL_W 4

// sram word index, 256 words
`define WB_MEM_AW 8

// wait state setting
`define WB_WAIT_W 3

`endif

// File: hdl/wb_pkg.sv
// ------------------------------------------------------------
// shared types of the wishbone memory link
// states, opcodes and the request and response bundles
// ------------------------------------------------------------
`default_nettype none

`include "wb_consts.svh"

package wb_pkg;

    // bus manager states
    typedef enum logic [1:0] {
        WB_IDLE  = 2'd0,
        WB_WRITE = 2'd1,
        WB_READ  = 2'd2
    } wb_state_t;

    // decoded user request
    typedef enum logic [1:0] {
        OP_NONE  = 2'd0,
        OP_WRITE = 2'd1,
        OP_READ  = 2'd2
    } wb_op_t;

    // request as the user design presents it
    typedef struct packed {
        logic [`WB_ADDR_W-1:0] adr;
        logic [`WB_DATA_W-1:0] dat;
        logic [`WB_SEL_W-1:0]  sel;
        logic                  write;
        logic                  read;
    } cpu_req_t;

    // manager to subordinate
    typedef struct packed {
        logic [`WB_ADDR_W-1:0] adr;
        logic [`WB_DATA_W-1:0] dat;
        logic [`WB_SEL_W-1:0]  sel;
        logic                  we;
        logic                  stb;
        logic                  cyc;
    } wb_req_t;

    // subordinate to manager
    typedef struct packed {
        logic [`WB_DATA_W-1:0] dat;
        logic                  ack;
    } wb_rsp_t;

endpackage

`default_nettype wire

// File: hdl/wishbone_manager.sv
// ------------------------------------------------------------
// single master wishbone bus manager
// turns one user read or write strobe into a classic cycle,
// holds busy until ack and registers the read data
// ------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "wb_consts.svh"

module wishbone_manager (
    input  logic                   CLK,
    input  logic                   nRST,
    input  wb_pkg::cpu_req_t       cpu_req,
    input  wb_pkg::wb_rsp_t        wb_rsp,
    output wb_pkg::wb_req_t        wb_req,
    output logic [`WB_DATA_W-1:0]  cpu_dat,
    output logic                   busy
);

    import wb_pkg::*;

    wb_state_t             state;
    wb_state_t             next_state;
    wb_op_t                op;
    wb_req_t               next_wb_req;
    logic [`WB_DATA_W-1:0] next_cpu_dat;
    logic                  next_busy;

    // exactly one of write and read makes a valid request
    always_comb begin
        op = OP_NONE;
        if (cpu_req.write && !cpu_req.read) begin
            op = OP_WRITE;
        end else if (cpu_req.read && !cpu_req.write) begin
            op = OP_READ;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state   <= WB_IDLE;
            wb_req  <= '0;
            cpu_dat <= '0;
            busy    <= 1'b0;
        end else begin
            state   <= next_state;
            wb_req  <= next_wb_req;
            cpu_dat <= next_cpu_dat;
            busy    <= next_busy;
        end
    end

    always_comb begin
        next_state   = state;
        next_wb_req  = wb_req;
        next_cpu_dat = cpu_dat;
        next_busy    = busy;

        case (state)
            WB_IDLE: begin
                if (op != OP_NONE) begin
                    // bus fields and strobes go out together
                    next_wb_req.adr = cpu_req.adr;
                    next_wb_req.dat = cpu_req.dat;
                    next_wb_req.sel = cpu_req.sel;
                    next_wb_req.we  = (op == OP_WRITE);
                    next_wb_req.stb = 1'b1;
                    next_wb_req.cyc = 1'b1;
                    next_busy       = 1'b1;
                end

                case (op)
                    OP_WRITE: next_state = WB_WRITE;
                    OP_READ:  next_state = WB_READ;
                    default:  next_state = WB_IDLE;
                endcase
            end

            WB_WRITE, WB_READ: begin
                // requests arriving here are dropped
                if (wb_rsp.ack) begin
                    next_state  = WB_IDLE;
                    next_wb_req = '0;
                    next_busy   = 1'b0;
                    if (state == WB_READ) begin
                        next_cpu_dat = wb_rsp.dat;
                    end
                end
            end

            default: begin
                next_state  = WB_IDLE;
                next_wb_req = '0;
                next_busy   = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/wait_state_timer.sv
// ------------------------------------------------------------
// wait state timer for the memory subordinate
// counts cycles of an open bus cycle, acks after wait_states
// ------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "wb_consts.svh"

module wait_state_timer (
    input  logic                  CLK,
    input  logic                  nRST,
    input  wb_pkg::wb_req_t       wb_req,
    input  logic [`WB_WAIT_W-1:0] wait_states,
    output logic                  ack
);

    // count stops at wait_states, so it cannot wrap before the match
    logic [`WB_WAIT_W-1:0] count;
    logic                  open;

    assign open = wb_req.cyc && wb_req.stb;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            count <= '0;
        end else if (open && !ack) begin
            count <= count + 1'b1;
        end else begin
            // idle or acked cycle starts over from zero
            count <= '0;
        end
    end

    // ack lasts one cycle, the manager drops stb on the next edge
    assign ack = wb_req.stb && (count == wait_states);

endmodule

`default_nettype wire

// File: hdl/wb_sram.sv
// ------------------------------------------------------------
// 256 word sram subordinate with byte lane writes
// read data follows adr, writes commit on the ack edge
// ------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "wb_consts.svh"

module wb_sram (
    input  logic                  CLK,
    input  logic                  nRST,
    input  wb_pkg::wb_req_t       wb_req,
    input  logic                  ack,
    output logic [`WB_DATA_W-1:0] rdat
);

    localparam int DEPTH = 1 << `WB_MEM_AW;

    logic [`WB_DATA_W-1:0] mem [DEPTH];
    logic [`WB_MEM_AW-1:0] idx;
    logic                  wr_en;

    // word index, higher address bits alias
    assign idx = wb_req.adr[`WB_MEM_AW+1:2];

    assign wr_en = wb_req.we && wb_req.stb && ack;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int w = 0; w < DEPTH; w++) begin
                mem[w] <= '0;
            end
        end else if (wr_en) begin
            // only the selected byte lanes change
            for (int b = 0; b < `WB_SEL_W; b++) begin
                if (wb_req.sel[b]) begin
                    mem[idx][b*8 +: 8] <= wb_req.dat[b*8 +: 8];
                end
            end
        end
    end

    assign rdat = mem[idx];

endmodule

`default_nettype wire

// File: hdl/wb_mem_system.sv
// ------------------------------------------------------------
// top level of the wishbone memory link
// bus manager, wait state timer and sram on one bus
// ------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "wb_consts.svh"

module wb_mem_system (
    input  logic                  CLK,
    input  logic                  nRST,
    input  wb_pkg::cpu_req_t      cpu_req,
    input  logic [`WB_WAIT_W-1:0] wait_states,
    output logic [`WB_DATA_W-1:0] cpu_dat,
    output logic                  busy,
    output wb_pkg::wb_req_t       wb_req,
    output wb_pkg::wb_rsp_t       wb_rsp
);

    logic                  ack;
    logic [`WB_DATA_W-1:0] rdat;

    // response is timer ack plus sram data
    assign wb_rsp.dat = rdat;
    assign wb_rsp.ack = ack;

    wishbone_manager u_manager (
        .CLK     (CLK),
        .nRST    (nRST),
        .cpu_req (cpu_req),
        .wb_rsp  (wb_rsp),
        .wb_req  (wb_req),
        .cpu_dat (cpu_dat),
        .busy    (busy)
    );

    wait_state_timer u_timer (
        .CLK         (CLK),
        .nRST        (nRST),
        .wb_req      (wb_req),
        .wait_states (wait_states),
        .ack         (ack)
    );

    wb_sram u_sram (
        .CLK    (CLK),
        .nRST   (nRST),
        .wb_req (wb_req),
        .ack    (ack),
        .rdat   (rdat)
    );

endmodule

`default_nettype wire

// File: sim/clock_gen.sv
// ------------------------------------------------------------
// testbench clock and power-on reset
// ------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 4
) (
    output logic CLK,
    output logic nRST
);

    initial begin
        CLK = 1'b0;
        forever #(PERIOD / 2) CLK = ~CLK;
    end

    // reset released on a rising edge
    initial begin
        nRST = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        nRST <= 1'b1;
    end

endmodule

`default_nettype wire

// File: sim/wb_mem_system_sva.sv
// ------------------------------------------------------------
// wishbone protocol assertions for the memory link
// bound into the top level by the testbench
// ------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module wb_mem_system_sva (
    input logic            CLK,
    input logic            nRST,
    input logic            busy,
    input wb_pkg::wb_req_t wb_req,
    input wb_pkg::wb_rsp_t wb_rsp
);

    // strobe and cycle always move together
    stb_cyc_equal: assert property (
        @(posedge CLK) disable iff (!nRST)
        wb_req.stb == wb_req.cyc
    ) else $error("stb and cyc differ");

    // bus fields hold while waiting for ack
    req_stable: assert property (
        @(posedge CLK) disable iff (!nRST)
        (wb_req.stb && !wb_rsp.ack) |=> $stable(wb_req)
    ) else $error("wb_req changed before ack");

    ack_in_cycle: assert property (
        @(posedge CLK) disable iff (!nRST)
        wb_rsp.ack |-> (wb_req.stb && wb_req.cyc && busy)
    ) else $error("ack outside of an open cycle");

    ack_one_cycle: assert property (
        @(posedge CLK) disable iff (!nRST)
        wb_rsp.ack |=> !wb_rsp.ack
    ) else $error("ack held longer than one cycle");

    // release follows ack directly
    busy_release: assert property (
        @(posedge CLK) disable iff (!nRST)
        wb_rsp.ack |=> !busy
    ) else $error("busy still high after ack");

endmodule

`default_nettype wire

// File: sim/tb_wb_mem_system.sv
// ------------------------------------------------------------
// testbench of the wishbone memory link
// random reads, writes and rejected requests against a word model
// ------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "wb_consts.svh"

module tb_wb_mem_system;

    import wb_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 4;
    localparam int MAX_WAIT     = (1 << `WB_WAIT_W) - 1;
    localparam int DEPTH        = 1 << `WB_MEM_AW;
    localparam int NUM_FIRST_RD = 8;
    localparam int NUM_RANDOM   = 400;
    localparam int NUM_TXN      = NUM_FIRST_RD + NUM_RANDOM + DEPTH;
    localparam int TIMEOUT_NS   = NUM_TXN * (MAX_WAIT + 4) * CLK_PERIOD
                                  + RESET_CYCLES * CLK_PERIOD;

    logic                  CLK;
    logic                  nRST;
    cpu_req_t              cpu_req;
    logic [`WB_WAIT_W-1:0] wait_states;
    logic [`WB_DATA_W-1:0] cpu_dat;
    logic                  busy;
    wb_req_t               wb_req;
    wb_rsp_t               wb_rsp;

    logic [`WB_DATA_W-1:0] model [DEPTH];
    logic [`WB_DATA_W-1:0] last_rd;
    integer                seed;

    clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) u_clk (
        .CLK  (CLK),
        .nRST (nRST)
    );

    wb_mem_system u_dut (
        .CLK         (CLK),
        .nRST        (nRST),
        .cpu_req     (cpu_req),
        .wait_states (wait_states),
        .cpu_dat     (cpu_dat),
        .busy        (busy),
        .wb_req      (wb_req),
        .wb_rsp      (wb_rsp)
    );

    bind wb_mem_system wb_mem_system_sva u_sva (
        .CLK    (CLK),
        .nRST   (nRST),
        .busy   (busy),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("error: time %0t signal %s expected 0x%08h actual 0x%08h",
                 $time, name, exp, act);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic report_failure(input string msg);
        $display("%s at time %0t", msg, $time);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        assert (exp === act) else report_mismatch(name, {31'd0, exp}, {31'd0, act});
    endtask

    task automatic check_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        assert (exp === act) else report_mismatch(name, exp, act);
    endtask

    // random upper and low bits alias onto word idx
    function automatic logic [31:0] make_adr(input logic [7:0] idx);
        logic [31:0] r;
        r = $random(seed);
        return {r[31:10], idx, r[1:0]};
    endfunction

    function automatic cpu_req_t make_req(input logic wr, input logic rd,
                                          input logic [7:0] idx);
        cpu_req_t    r;
        logic [31:0] rnd;
        rnd     = $random(seed);
        r.adr   = make_adr(idx);
        r.dat   = $random(seed);
        r.sel   = rnd[3:0];
        r.write = wr;
        r.read  = rd;
        return r;
    endfunction

    // any combination of strobes, used while the bus is busy
    function automatic cpu_req_t junk_req();
        logic [31:0] rnd;
        rnd = $random(seed);
        return make_req(rnd[0], rnd[1], rnd[15:8]);
    endfunction

    task automatic reject_request(input cpu_req_t req);
        @(posedge CLK);
        cpu_req <= req;
        @(posedge CLK);
        cpu_req <= '0;
        @(negedge CLK);
        check_bit("busy", 1'b0, busy);
        check_bit("wb_req.stb", 1'b0, wb_req.stb);
    endtask

    task automatic run_access(input cpu_req_t req, input logic [2:0] ws, input logic junk);
        int         n;
        logic       acked;
        logic [7:0] idx;
        idx = req.adr[9:2];
        @(posedge CLK);
        wait_states <= ws;
        cpu_req     <= req;
        @(negedge CLK);
        check_bit("busy", 1'b0, busy);
        @(posedge CLK);
        cpu_req <= junk ? junk_req() : '0;
        n = 0;
        @(negedge CLK);
        check_bit("busy", 1'b1, busy);
        // bus fields follow the accepted request
        check_word("wb_req.adr", req.adr, wb_req.adr);
        check_word("wb_req.dat", req.dat, wb_req.dat);
        check_word("wb_req.sel", {28'd0, req.sel}, {28'd0, wb_req.sel});
        check_bit("wb_req.we", req.write, wb_req.we);
        check_bit("wb_req.cyc", 1'b1, wb_req.cyc);
        check_word("wb_rsp.dat", model[idx], wb_rsp.dat);
        while (busy) begin
            assert (n <= int'(ws))
                else report_failure("busy stayed high longer than wait_states+1 cycles");
            check_bit("wb_rsp.ack", n == int'(ws), wb_rsp.ack);
            acked = wb_rsp.ack;
            n++;
            @(posedge CLK);
            // the request line is quiet again by the release edge
            cpu_req <= (junk && !acked) ? junk_req() : '0;
            @(negedge CLK);
        end
        check_word("busy cycles", int'(ws) + 1, n);
        // released bus is all zero
        check_bit("wb_req.stb", 1'b0, wb_req.stb);
        check_bit("wb_req.cyc", 1'b0, wb_req.cyc);
        check_bit("wb_req.we", 1'b0, wb_req.we);
        check_word("wb_req.adr", '0, wb_req.adr);
        check_word("wb_req.dat", '0, wb_req.dat);
        if (req.read) begin
            check_word("cpu_dat", model[idx], cpu_dat);
            last_rd = model[idx];
        end else begin
            for (int b = 0; b < 4; b++) begin
                if (req.sel[b]) begin
                    model[idx][b*8 +: 8] = req.dat[b*8 +: 8];
                end
            end
            check_word("cpu_dat", last_rd, cpu_dat);
        end
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the transactions did not finish in the expected time");
        $display("Regression failed");
        $fatal(1);
    end

    initial begin
        logic [31:0] rnd;
        cpu_req     = '0;
        wait_states = '0;
        seed        = 32'h22088779;
        last_rd     = '0;
        for (int w = 0; w < DEPTH; w++) begin
            model[w] = '0;
        end

        wait (nRST === 1'b1);
        @(negedge CLK);
        check_bit("busy", 1'b0, busy);
        check_bit("wb_req.stb", 1'b0, wb_req.stb);
        check_bit("wb_req.cyc", 1'b0, wb_req.cyc);
        check_bit("wb_req.we", 1'b0, wb_req.we);
        check_bit("wb_rsp.ack", 1'b0, wb_rsp.ack);
        check_word("cpu_dat", '0, cpu_dat);

        // memory reads zero before any write
        for (int i = 0; i < NUM_FIRST_RD; i++) begin
            rnd = $random(seed);
            run_access(make_req(1'b0, 1'b1, rnd[7:0]), rnd[10:8], 1'b0);
        end

        // small index range so reads hit earlier writes
        for (int i = 0; i < NUM_RANDOM; i++) begin
            rnd = $random(seed);
            case (rnd[5:3])
                3'd0, 3'd1, 3'd2:
                    run_access(make_req(1'b1, 1'b0, {3'd0, rnd[20:16]}), rnd[2:0], rnd[6]);
                3'd3, 3'd4, 3'd5:
                    run_access(make_req(1'b0, 1'b1, {3'd0, rnd[20:16]}), rnd[2:0], rnd[6]);
                3'd6:
                    reject_request(make_req(1'b1, 1'b1, {3'd0, rnd[20:16]}));
                default:
                    reject_request(make_req(1'b0, 1'b0, {3'd0, rnd[20:16]}));
            endcase
        end

        for (int w = 0; w < DEPTH; w++) begin
            rnd = $random(seed);
            run_access(make_req(1'b0, 1'b1, 8'(w)), rnd[2:0], 1'b0);
        end

        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+include
hdl/wb_pkg.sv
hdl/wishbone_manager.sv
hdl/wait_state_timer.sv
hdl/wb_sram.sv
hdl/wb_mem_system.sv
sim/clock_gen.sv
sim/wb_mem_system_sva.sv
sim/tb_wb_mem_system.sv

// File: Makefile
# Verilator build and run of the wishbone memory link testbench

VERILATOR := verilator
TOP       := tb_wb_mem_system
FILELIST  := src.f
BUILD_DIR := obj_dir
LOG       := sim.log
VFLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir $(BUILD_DIR)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

# the log decides pass or fail
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Regression failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "Regression passed" $(LOG); then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
